// File: design/mips_pkg.sv
// mips core shared definitions
package mips_pkg;

   // basic widths
   typedef logic [31:0] word_t;      // data word
   typedef logic [29:0] word_addr_t; // word address, byte offset dropped
   typedef logic [3:0]  byte_en_t;   // byte write mask
   typedef logic [4:0]  reg_idx_t;   // register number

   localparam word_t    TEXT_START   = 32'h0040_0000; // reset pc
   localparam reg_idx_t REG_V0       = 5'd2;          // syscall code lives here
   localparam reg_idx_t REG_RA       = 5'd31;         // link register
   localparam word_t    SYSCALL_EXIT = 32'd10;        // $v0 value that halts

   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SW      = 6'h2b
   } opcode_e;

   // funct field of SPECIAL, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_MFHI    = 6'h10,
      FN_MTHI    = 6'h11,
      FN_MFLO    = 6'h12,
      FN_MTLO    = 6'h13,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV,
      ALU_SRAV, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT
   } alu_op_e;

   // load extraction, lui rides the same path
   typedef enum logic [2:0] {
      LOAD_LUI, LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LBU, LOAD_LHU
   } load_kind_e;

   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP} pc_src_e;
   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_HI, WB_LO} wb_src_e;

endpackage

// File: design/mips_decode.sv
// mips instruction decoder
`timescale 1ns/10ps

module mips_decode (
   input  mips_pkg::opcode_e    opcode,
   input  mips_pkg::funct_e     funct,
   output mips_pkg::alu_op_e    alu_op,
   output mips_pkg::pc_src_e    pc_src,
   output logic                 branch_on_equal,
   output logic                 is_branch,
   output logic                 reg_dst_rd,
   output logic                 alu_src_imm,
   output logic                 sign_extend,
   output logic                 reg_write,
   output logic                 link,
   output logic                 store,
   output logic                 hi_write,
   output logic                 lo_write,
   output logic                 syscall,
   output logic                 reserved,
   output mips_pkg::load_kind_e load_kind,
   output mips_pkg::wb_src_e    wb_src
);

   always_comb begin
      // nop-like defaults
      alu_op          = mips_pkg::ALU_ADD;
      pc_src          = mips_pkg::PC_SEQ;
      branch_on_equal = 1'b0;
      is_branch       = 1'b0;
      reg_dst_rd      = 1'b0;
      alu_src_imm     = 1'b0;
      sign_extend     = 1'b0;
      reg_write       = 1'b0;
      link            = 1'b0;
      store           = 1'b0;
      hi_write        = 1'b0;
      lo_write        = 1'b0;
      syscall         = 1'b0;
      reserved        = 1'b0;
      load_kind       = mips_pkg::LOAD_LW;
      wb_src          = mips_pkg::WB_ALU;

      case (opcode)
         mips_pkg::OP_SPECIAL: begin
            reg_dst_rd = 1'b1; // r-type writes rd
            reg_write  = 1'b1; // cleared below for the non-writers
            case (funct)
               mips_pkg::FN_ADD,
               mips_pkg::FN_ADDU:    alu_op = mips_pkg::ALU_ADD; // no overflow trap
               mips_pkg::FN_SUB,
               mips_pkg::FN_SUBU:    alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:     alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:      alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:     alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:     alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:     alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLL:     alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:     alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:     alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_SLLV:    alu_op = mips_pkg::ALU_SLLV;
               mips_pkg::FN_SRLV:    alu_op = mips_pkg::ALU_SRLV;
               mips_pkg::FN_SRAV:    alu_op = mips_pkg::ALU_SRAV;
               mips_pkg::FN_MFHI:    wb_src = mips_pkg::WB_HI;
               mips_pkg::FN_MFLO:    wb_src = mips_pkg::WB_LO;
               mips_pkg::FN_MTHI: begin
                  reg_write = 1'b0;
                  hi_write  = 1'b1; // hi <- rs
               end
               mips_pkg::FN_MTLO: begin
                  reg_write = 1'b0;
                  lo_write  = 1'b1;
               end
               mips_pkg::FN_JR: begin
                  reg_write = 1'b0;
                  pc_src    = mips_pkg::PC_REG; // pc <- rs
               end
               mips_pkg::FN_SYSCALL: begin
                  reg_write = 1'b0;
                  syscall   = 1'b1; // core checks $v0
               end
               default: begin
                  reg_write = 1'b0;
                  reserved  = 1'b1; // unknown funct
               end
            endcase
         end
         mips_pkg::OP_ADDI,
         mips_pkg::OP_ADDIU: begin
            alu_src_imm = 1'b1;
            sign_extend = 1'b1;
            reg_write   = 1'b1;
         end
         mips_pkg::OP_SLTI: begin
            alu_op      = mips_pkg::ALU_SLT;
            alu_src_imm = 1'b1;
            sign_extend = 1'b1; // signed imm and signed compare
            reg_write   = 1'b1;
         end
         mips_pkg::OP_ANDI,
         mips_pkg::OP_ORI,
         mips_pkg::OP_XORI: begin
            alu_src_imm = 1'b1; // zero-extended imm
            reg_write   = 1'b1;
            if (opcode == mips_pkg::OP_ANDI)
               alu_op = mips_pkg::ALU_AND;
            else if (opcode == mips_pkg::OP_ORI)
               alu_op = mips_pkg::ALU_OR;
            else
               alu_op = mips_pkg::ALU_XOR;
         end
         mips_pkg::OP_LUI: begin
            reg_write = 1'b1;
            wb_src    = mips_pkg::WB_LOAD;
            load_kind = mips_pkg::LOAD_LUI; // imm into upper half
         end
         mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
         mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
            alu_src_imm = 1'b1; // address = rs + se(imm)
            sign_extend = 1'b1;
            reg_write   = 1'b1;
            wb_src      = mips_pkg::WB_LOAD;
            case (opcode)
               mips_pkg::OP_LB:  load_kind = mips_pkg::LOAD_LB;
               mips_pkg::OP_LH:  load_kind = mips_pkg::LOAD_LH;
               mips_pkg::OP_LBU: load_kind = mips_pkg::LOAD_LBU;
               mips_pkg::OP_LHU: load_kind = mips_pkg::LOAD_LHU;
               default:          load_kind = mips_pkg::LOAD_LW;
            endcase
         end
         mips_pkg::OP_SW: begin
            alu_src_imm = 1'b1;
            sign_extend = 1'b1;
            store       = 1'b1; // full word only
         end
         mips_pkg::OP_BEQ,
         mips_pkg::OP_BNE: begin
            is_branch       = 1'b1; // rs==rt compare sits in the core
            branch_on_equal = (opcode == mips_pkg::OP_BEQ);
            pc_src          = mips_pkg::PC_BRANCH;
         end
         mips_pkg::OP_J:   pc_src = mips_pkg::PC_JUMP;
         mips_pkg::OP_JAL: begin
            pc_src    = mips_pkg::PC_JUMP;
            link      = 1'b1; // $ra <- pc+4
            reg_write = 1'b1;
         end
         default: reserved = 1'b1;
      endcase
   end

endmodule

// File: design/mips_alu.sv
// mips integer alu
`timescale 1ns/10ps

module mips_alu (
   input  mips_pkg::word_t   a,      // rs side
   input  mips_pkg::word_t   b,      // rt or immediate
   input  logic [4:0]        shamt,  // inst[10:6]
   input  mips_pkg::alu_op_e op,
   output mips_pkg::word_t   result
);

   logic [4:0] var_shamt; // variable shifts use rs[4:0]

   assign var_shamt = a[4:0];

   always_comb begin
      case (op)
         mips_pkg::ALU_ADD:
            result = a + b; // wraps, no trap
         mips_pkg::ALU_SUB:
            result = a - b;
         mips_pkg::ALU_SLL:
            result = b << shamt;
         mips_pkg::ALU_SRL:
            result = b >> shamt;
         mips_pkg::ALU_SRA:
            result = $signed(b) >>> shamt; // sign fill
         mips_pkg::ALU_SLLV:
            result = b << var_shamt;
         mips_pkg::ALU_SRLV:
            result = b >> var_shamt;
         mips_pkg::ALU_SRAV:
            result = $signed(b) >>> var_shamt;
         mips_pkg::ALU_AND:
            result = a & b;
         mips_pkg::ALU_OR:
            result = a | b;
         mips_pkg::ALU_XOR:
            result = a ^ b;
         mips_pkg::ALU_NOR:
            result = ~(a | b);
         mips_pkg::ALU_SLT:
            result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // signed compare
         default:
            result = '0;
      endcase
   end

endmodule

// File: design/mips_regfile.sv
// mips register file
`timescale 1ns/10ps

module mips_regfile (
   input  logic              clk,
   input  logic              rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   input  logic              wr_en,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t   wr_data,
   output mips_pkg::word_t   rs_data,
   output mips_pkg::word_t   rt_data
);

   mips_pkg::word_t regs [32]; // regs[0] never written

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en && wr_idx != '0) begin
         regs[wr_idx] <= wr_data; // r0 writes dropped
      end
   end

   // combinational reads, r0 hardwired
   assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
   assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

   // write index must be known whenever a write is requested
   a_wr_idx_known: assert property (
      @(posedge clk) disable iff (!rst_b) wr_en |-> !$isunknown(wr_idx)
   ) else $error("regfile: write with unknown index");

endmodule

// File: design/mips_core.sv
// single-cycle mips core
`timescale 1ns/10ps

module mips_core (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   input  mips_pkg::word_t      mem_data_out,
   output mips_pkg::byte_en_t   mem_write_en,
   output logic                 halted
);

   mips_pkg::word_t      pc, pc_plus4, next_pc, br_target, j_target;
   mips_pkg::word_t      rs_data, rt_data, imm_ext, alu_b, alu_result;
   mips_pkg::word_t      load_data, wb_data, wr_data, hi, lo;
   mips_pkg::reg_idx_t   rs, rt, rd, rt_rd_idx, wr_idx;
   logic [4:0]           shamt;
   logic [15:0]          imm;
   logic [25:0]          target;
   mips_pkg::opcode_e    opcode;
   mips_pkg::funct_e     funct;
   mips_pkg::alu_op_e    alu_op;
   mips_pkg::pc_src_e    pc_src;
   mips_pkg::load_kind_e load_kind;
   mips_pkg::wb_src_e    wb_src;
   logic branch_on_equal, is_branch, reg_dst_rd, alu_src_imm, sign_extend;
   logic reg_write, link, store, hi_write, lo_write, syscall, reserved;
   logic rs_eq_rt, br_taken, halt_now, commit;

   // instruction fields
   assign opcode = mips_pkg::opcode_e'(inst[31:26]);
   assign funct  = mips_pkg::funct_e'(inst[5:0]);
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign imm    = inst[15:0];
   assign target = inst[25:0];

   mips_decode decoder0 (
      .opcode          (opcode),
      .funct           (funct),
      .alu_op          (alu_op),
      .pc_src          (pc_src),
      .branch_on_equal (branch_on_equal),
      .is_branch       (is_branch),
      .reg_dst_rd      (reg_dst_rd),
      .alu_src_imm     (alu_src_imm),
      .sign_extend     (sign_extend),
      .reg_write       (reg_write),
      .link            (link),
      .store           (store),
      .hi_write        (hi_write),
      .lo_write        (lo_write),
      .syscall         (syscall),
      .reserved        (reserved),
      .load_kind       (load_kind),
      .wb_src          (wb_src)
   );

   // exit syscall or reserved encoding halts and nothing retires after
   assign halt_now = reserved || (syscall && rt_data == mips_pkg::SYSCALL_EXIT);
   assign commit   = !halted && !halt_now; // qualifies every write enable

   // syscall borrows the rt port to look at $v0
   assign rt_rd_idx = syscall ? mips_pkg::REG_V0 : rt;
   assign wr_idx    = link ? mips_pkg::REG_RA : (reg_dst_rd ? rd : rt);
   assign wr_data   = link ? pc_plus4 : wb_data; // jal links pc+4 as there is no delay slot

   mips_regfile regfile0 (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs),
      .rt_idx  (rt_rd_idx),
      .wr_en   (reg_write && commit),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   // operand b is rt or the zero/sign-extended imm
   assign imm_ext = sign_extend ? {{16{imm[15]}}, imm} : {16'h0000, imm};
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;

   mips_alu alu0 (
      .a      (rs_data),
      .b      (alu_b),
      .shamt  (shamt),
      .op     (alu_op),
      .result (alu_result)
   );

   // loads take the low bits of the addressed word
   always_comb begin
      case (load_kind)
         mips_pkg::LOAD_LUI: load_data = {imm, 16'h0000};
         mips_pkg::LOAD_LB:  load_data = {{24{mem_data_out[7]}}, mem_data_out[7:0]};
         mips_pkg::LOAD_LH:  load_data = {{16{mem_data_out[15]}}, mem_data_out[15:0]};
         mips_pkg::LOAD_LBU: load_data = {24'h000000, mem_data_out[7:0]};
         mips_pkg::LOAD_LHU: load_data = {16'h0000, mem_data_out[15:0]};
         default:            load_data = mem_data_out; // lw
      endcase
   end

   always_comb begin
      case (wb_src)
         mips_pkg::WB_LOAD: wb_data = load_data;
         mips_pkg::WB_HI:   wb_data = hi;
         mips_pkg::WB_LO:   wb_data = lo;
         default:           wb_data = alu_result;
      endcase
   end

   // next pc
   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
   assign j_target  = {pc[31:28], target, 2'b00};
   assign rs_eq_rt  = (rs_data == rt_data);
   assign br_taken  = is_branch && (rs_eq_rt == branch_on_equal); // beq or bne

   always_comb begin
      case (pc_src)
         mips_pkg::PC_BRANCH: next_pc = br_taken ? br_target : pc_plus4;
         mips_pkg::PC_REG:    next_pc = rs_data; // jr
         mips_pkg::PC_JUMP:   next_pc = j_target;
         default:             next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= mips_pkg::TEXT_START;
         halted <= 1'b0;
      end else begin
         if (commit)
            pc <= next_pc; // frozen once halting
         halted <= halted || halt_now; // sticky until reset
      end
   end

   // hi/lo both load from rs
   always_ff @(posedge clk) begin
      if (hi_write && commit)
         hi <= rs_data;
      if (lo_write && commit)
         lo <= rs_data;
   end

   // memory ports
   assign inst_addr    = pc[31:2];
   assign mem_addr     = alu_result[31:2];
   assign mem_data_in  = rt_data;
   assign mem_write_en = (store && commit) ? 4'b1111 : 4'b0000;

   a_pc_aligned: assert property (
      @(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00
   ) else $error("core: pc %h not word aligned", pc);

endmodule

// File: verification/tb_clock.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clock (
   input  logic restart, // rising edge starts a new reset
   output logic clk,
   output logic rst_b
);

   logic [3:0] rst_cnt = 4'd8; // reset cycles still to go

   initial clk = 1'b0;
   always #5 clk = ~clk; // 10 ns period

   always @(posedge clk or posedge restart) begin
      if (restart)
         rst_cnt <= 4'd8;
      else if (rst_cnt != 4'd0)
         rst_cnt <= rst_cnt - 4'd1;
   end

   assign rst_b = (rst_cnt == 4'd0);

endmodule

// File: verification/mips_ref.svh
// mips encoders, programs and isa model
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

function automatic mips_pkg::word_t enc_r(mips_pkg::funct_e fn, mips_pkg::reg_idx_t rs,
      mips_pkg::reg_idx_t rt, mips_pkg::reg_idx_t rd, logic [4:0] sh);
   return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic mips_pkg::word_t enc_i(mips_pkg::opcode_e op, mips_pkg::reg_idx_t rs,
      mips_pkg::reg_idx_t rt, logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// jump to word idx of the current program
function automatic mips_pkg::word_t enc_j(mips_pkg::opcode_e op, int idx);
   mips_pkg::word_t tgt;
   tgt = mips_pkg::TEXT_START + 32'(idx * 4);
   return {op, tgt[27:2]};
endfunction

task automatic emit(mips_pkg::word_t w);
   prog[cur][prog_len[cur]] = w;
   prog_len[cur]++;
endtask

task automatic load_imm(mips_pkg::reg_idx_t r, mips_pkg::word_t v);
   emit(enc_i(mips_pkg::OP_LUI, 5'd0, r, v[31:16]));
   emit(enc_i(mips_pkg::OP_ORI, r, r, v[15:0]));
endtask

// sw r11 to the next result slot
task automatic store_res();
   emit(enc_i(mips_pkg::OP_SW, 5'd0, 5'd11, st_off));
   st_off += 16'd4;
endtask

task automatic emit_exit();
   emit(enc_i(mips_pkg::OP_ORI, 5'd0, mips_pkg::REG_V0, 16'd10));
   emit(enc_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
endtask

task automatic start_prog(int t);
   cur = t;
   prog_len[t] = 0;
   st_off = 16'h0100; // results land above the load data
endtask

// one instruction of the isa on the model state
function automatic void ref_step(output mips_pkg::word_addr_t st_addr,
      output mips_pkg::word_t st_data, output mips_pkg::byte_en_t st_en);
   mips_pkg::word_t ins, rsv, rtv, sei, zei, ea, w, res, npc;
   logic [5:0] op, fn;
   logic [4:0] rs, rt, rd, sh, dst;
   logic wr, halt;
   ins = imem[ref_pc[9:2]];
   st_addr = '0;
   st_data = '0;
   st_en = '0;
   if (ref_halted)
      return; // frozen
   op = ins[31:26];
   fn = ins[5:0];
   rs = ins[25:21];
   rt = ins[20:16];
   rd = ins[15:11];
   sh = ins[10:6];
   rsv = ref_regs[rs];
   rtv = ref_regs[rt];
   sei = {{16{ins[15]}}, ins[15:0]};
   zei = {16'h0000, ins[15:0]};
   ea = rsv + sei;
   w = ref_dmem[ea[9:2]];
   npc = ref_pc + 32'd4;
   res = '0;
   dst = rt;
   wr = 1'b1;
   halt = 1'b0;
   case (op)
      6'h00: begin
         dst = rd;
         case (fn)
            6'h20, 6'h21: res = rsv + rtv; // add never traps here
            6'h22, 6'h23: res = rsv - rtv;
            6'h24: res = rsv & rtv;
            6'h25: res = rsv | rtv;
            6'h26: res = rsv ^ rtv;
            6'h27: res = ~(rsv | rtv);
            6'h2a: res = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
            6'h00: res = rtv << sh;
            6'h02: res = rtv >> sh;
            6'h03: res = $signed(rtv) >>> sh;
            6'h04: res = rtv << rsv[4:0];
            6'h06: res = rtv >> rsv[4:0];
            6'h07: res = $signed(rtv) >>> rsv[4:0];
            6'h10: res = ref_hi;
            6'h12: res = ref_lo;
            6'h11: begin wr = 1'b0; ref_hi = rsv; end
            6'h13: begin wr = 1'b0; ref_lo = rsv; end
            6'h08: begin wr = 1'b0; npc = rsv; end
            6'h0c: begin wr = 1'b0; halt = (ref_regs[2] == 32'd10); end
            default: halt = 1'b1;
         endcase
      end
      6'h02: begin wr = 1'b0; npc = {ref_pc[31:28], ins[25:0], 2'b00}; end
      6'h03: begin
         npc = {ref_pc[31:28], ins[25:0], 2'b00};
         dst = 5'd31;
         res = ref_pc + 32'd4; // no delay slot
      end
      6'h04, 6'h05: begin
         wr = 1'b0;
         if ((rsv == rtv) == (op == 6'h04))
            npc = ref_pc + 32'd4 + (sei << 2);
      end
      6'h08, 6'h09: res = rsv + sei;
      6'h0a: res = ($signed(rsv) < $signed(sei)) ? 32'd1 : 32'd0;
      6'h0c: res = rsv & zei;
      6'h0d: res = rsv | zei;
      6'h0e: res = rsv ^ zei;
      6'h0f: res = {ins[15:0], 16'h0000};
      6'h20: res = {{24{w[7]}}, w[7:0]};
      6'h21: res = {{16{w[15]}}, w[15:0]};
      6'h23: res = w;
      6'h24: res = {24'h000000, w[7:0]};
      6'h25: res = {16'h0000, w[15:0]};
      6'h2b: begin
         wr = 1'b0;
         st_addr = ea[31:2];
         st_data = rtv;
         st_en = 4'b1111;
         ref_dmem[ea[9:2]] = rtv;
      end
      default: halt = 1'b1;
   endcase
   if (halt) begin
      ref_halted = 1'b1;
      return;
   end
   if (wr && dst != 5'd0)
      ref_regs[dst] = res;
   ref_pc = npc;
endfunction

`endif

// File: verification/mips_tb.sv
// mips core testbench
`timescale 1ns/10ps

module mips_tb;

   localparam int NUM_TESTS = 6;

   logic clk, rst_b, restart, halted, checking;
   mips_pkg::word_t      inst, mem_data_in, mem_data_out;
   mips_pkg::word_addr_t inst_addr, mem_addr;
   mips_pkg::byte_en_t   mem_write_en;
   mips_pkg::word_t      imem [256];
   mips_pkg::word_t      dmem [256];
   mips_pkg::word_t      prog [NUM_TESTS][256];
   int                   prog_len [NUM_TESTS];
   int                   cur, wd_cycles;
   int                   seed = 88;
   logic [15:0]          st_off;
   // isa model state
   mips_pkg::word_t      ref_regs [32];
   mips_pkg::word_t      ref_dmem [256];
   mips_pkg::word_t      ref_pc, ref_hi, ref_lo;
   logic                 ref_halted;

   `include "mips_ref.svh"

   tb_clock clock0 (.restart(restart), .clk(clk), .rst_b(rst_b));

   mips_core dut0 (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   // both memories read combinationally
   assign inst         = imem[inst_addr[7:0]];
   assign mem_data_out = dmem[mem_addr[7:0]];

   always @(posedge clk) begin
      if (rst_b && mem_write_en == 4'b1111)
         dmem[mem_addr[7:0]] <= mem_data_in;
   end

   task automatic report_mismatch(string name, mips_pkg::word_t exp, mips_pkg::word_t got);
      $display("** Error %s expected %h got %h", name, exp, got);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_word(string name, mips_pkg::word_t exp, mips_pkg::word_t got);
      if (exp !== got)
         report_mismatch(name, exp, got);
   endtask

   task automatic check_addr(string name, mips_pkg::word_addr_t exp,
         mips_pkg::word_addr_t got);
      if (exp !== got)
         report_mismatch(name, 32'(exp), 32'(got));
   endtask

   task automatic check_en(string name, mips_pkg::byte_en_t exp, mips_pkg::byte_en_t got);
      if (exp !== got)
         report_mismatch(name, 32'(exp), 32'(got));
   endtask

   task automatic check_bit(string name, logic exp, logic got);
      if (exp !== got)
         report_mismatch(name, 32'(exp), 32'(got));
   endtask

   // compare ports against the model, mid-cycle when all is settled
   always @(negedge clk) begin : compare
      mips_pkg::word_addr_t exp_addr;
      mips_pkg::word_t      exp_data;
      mips_pkg::byte_en_t   exp_en;
      if (checking) begin
         check_addr("inst_addr", ref_pc[31:2], inst_addr);
         check_bit("halted", ref_halted, halted);
         ref_step(exp_addr, exp_data, exp_en);
         check_en("mem_write_en", exp_en, mem_write_en);
         if (exp_en != 4'b0000) begin
            check_addr("mem_addr", exp_addr, mem_addr);
            check_word("mem_data_in", exp_data, mem_data_in);
         end
      end
   end

   task automatic build_alu();
      mips_pkg::funct_e  fns [15] = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
         mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR,
         mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLL, mips_pkg::FN_SRL,
         mips_pkg::FN_SRA, mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV};
      mips_pkg::opcode_e ops [7] = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI,
         mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_SLTI, mips_pkg::OP_LUI};
      mips_pkg::word_t   rnd;
      start_prog(0);
      for (int pass = 0; pass < 2; pass++) begin // two operand sets
         load_imm(5'd8, $random(seed));
         load_imm(5'd9, $random(seed));
         for (int i = 0; i < 15; i++) begin
            rnd = $random(seed);
            emit(enc_r(fns[i], 5'd8, 5'd9, 5'd11, rnd[4:0]));
            store_res();
         end
         for (int i = 0; i < 7; i++) begin
            rnd = $random(seed);
            emit(enc_i(ops[i], 5'd8, 5'd11, rnd[15:0]));
            store_res();
         end
      end
      emit_exit();
   endtask

   task automatic build_loads();
      mips_pkg::opcode_e lds [5] = '{mips_pkg::OP_LW, mips_pkg::OP_LB, mips_pkg::OP_LH,
         mips_pkg::OP_LBU, mips_pkg::OP_LHU};
      start_prog(1);
      for (int i = 0; i < 5; i++) begin
         emit(enc_i(lds[i], 5'd0, 5'd11, 16'h0004)); // byte pos, half neg
         store_res();
         load_imm(5'd8, 32'h0000_03e0);
         emit(enc_i(lds[i], 5'd8, 5'd11, 16'h0010)); // byte neg, half pos
         store_res();
      end
      emit_exit();
   endtask

   task automatic build_branches();
      start_prog(2);
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd8, 16'd5));
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd9, 16'd5));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd8, 5'd9, 16'd1));     // taken
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0bad)); // skipped
      emit(enc_i(mips_pkg::OP_BNE, 5'd8, 5'd9, 16'd1));     // not taken
      emit(enc_i(mips_pkg::OP_BEQ, 5'd8, 5'd0, 16'd1));     // not taken
      emit(enc_i(mips_pkg::OP_BNE, 5'd8, 5'd0, 16'd1));     // taken
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0bad));
      emit(enc_j(mips_pkg::OP_J, 10));
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0bad));
      emit(enc_j(mips_pkg::OP_JAL, 13));                     // word 10
      emit(enc_i(mips_pkg::OP_SW, 5'd0, 5'd31, 16'h0200));  // after return
      emit(enc_j(mips_pkg::OP_J, 15));
      emit(enc_i(mips_pkg::OP_SW, 5'd0, 5'd31, 16'h0204));  // link value
      emit(enc_r(mips_pkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
      emit_exit();                                           // word 15
   endtask

   task automatic build_hilo();
      start_prog(3);
      load_imm(5'd8, $random(seed));
      load_imm(5'd9, $random(seed));
      emit(enc_r(mips_pkg::FN_MTHI, 5'd8, 5'd0, 5'd0, 5'd0));
      emit(enc_r(mips_pkg::FN_MTLO, 5'd9, 5'd0, 5'd0, 5'd0));
      emit(enc_r(mips_pkg::FN_MFHI, 5'd0, 5'd0, 5'd11, 5'd0));
      store_res();
      emit(enc_r(mips_pkg::FN_MFLO, 5'd0, 5'd0, 5'd11, 5'd0));
      store_res();
      emit_exit();
   endtask

   task automatic build_halts();
      start_prog(4);
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, mips_pkg::REG_V0, 16'd4));
      emit(enc_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0)); // just a no-op
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0077));
      store_res();
      emit_exit();
      store_res(); // never reached
      start_prog(5);
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0055));
      store_res();
      emit(32'hfc00_0000); // opcode 0x3f is reserved
      store_res();
   endtask

   task automatic run_test(int t);
      checking = 1'b0;
      @(negedge clk);
      restart = 1'b1;
      @(negedge clk);
      restart = 1'b0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = (i < prog_len[t]) ? prog[t][i] : (32'hfc00_0000 | 32'(i));
         dmem[i] = {~8'(i), 8'(i), 8'(i) ^ 8'h80, 8'(i)};
         ref_dmem[i] = dmem[i];
      end
      for (int i = 0; i < 32; i++)
         ref_regs[i] = '0;
      ref_pc = mips_pkg::TEXT_START;
      ref_halted = 1'b0;
      wait (rst_b);
      checking = 1'b1;
      if (t == 0) begin
         @(negedge clk);
         check_addr("inst_addr", mips_pkg::TEXT_START[31:2], inst_addr);
         check_bit("halted", 1'b0, halted);
         check_en("mem_write_en", 4'b0000, mem_write_en);
      end
      wait (halted);
      repeat (11) @(negedge clk); // frozen pc and no stores
   endtask

   initial begin
      restart = 1'b0;
      checking = 1'b0;
      wd_cycles = 0;
      build_alu();
      build_loads();
      build_branches();
      build_hilo();
      build_halts();
      for (int t = 0; t < NUM_TESTS; t++)
         wd_cycles += prog_len[t] + 20 + 12; // plus reset and hold time
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("PASS: all tests");
      $finish;
   end

   // watchdog
   initial begin
      wait (wd_cycles != 0);
      #(wd_cycles * 10);
      $display("timeout: the core did not halt within %0d cycles", wd_cycles);
      $display("FAIL: see errors above");
      $fatal(1);
   end

endmodule

// File: sim.f
+incdir+verification
design/mips_pkg.sv
design/mips_decode.sv
design/mips_alu.sv
design/mips_regfile.sv
design/mips_core.sv
verification/tb_clock.sv
verification/mips_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mips core testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module mips_tb -f sim.f -o mips_sim &&
./obj_dir/mips_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
